// ==== list.f ====
+incdir+design
design/rv_pkg.sv
design/rv_control_unit.sv
design/rv_sign_ex.sv
design/rv_branch_unit.sv
design/rv_instr_decode.sv
design/rv_reg_file.sv
design/rv_alu.sv
design/rv_exec_top.sv
dv/rv_exec_assertions.sv
dv/tb_rv_exec.sv

// ==== dv/tb_rv_exec.sv ====
// testbench for the rv32i execute slice with reset, directed and lcg-driven instruction stream

`include "rv_cfg.svh"

module tb_rv_exec
    import rv_pkg::*;
();

    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_NUM     = 400;
    localparam int TIMEOUT_CYCLES = 500;   // 16 reset + 20 directed + 400 random + 25 bubbles

    logic        clk = 1'b0;
    logic        arst_n;
    word_t       instr;
    logic        instr_vld;
    logic        rf_we;
    reg_addr_t   rf_wa;
    word_t       rf_wd;
    logic        dm_we;
    word_t       dm_addr;
    word_t       dm_wdata;
    logic        pc_src;
    word_t       br_offset;
    word_t       shadow [`RV_REG_NUM];     // architectural copy fed by write-back
    word_t       rs1_val;
    word_t       rs2_val;
    logic [31:0] lcg_state = 32'hcdb9636f;
    int          cycle_cnt = 0;

    always #5 clk = ~clk;

    rv_exec_top rv_exec_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr     (instr),
        .instr_vld (instr_vld),
        .rf_we     (rf_we),
        .rf_wa     (rf_wa),
        .rf_wd     (rf_wd),
        .dm_we     (dm_we),
        .dm_addr   (dm_addr),
        .dm_wdata  (dm_wdata),
        .pc_src    (pc_src),
        .br_offset (br_offset)
    );

    bind rv_exec_top rv_exec_assertions rv_exec_assertions_i (
        .*,
        .rs1_val (tb_rv_exec.rs1_val),
        .rs2_val (tb_rv_exec.rs2_val)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                shadow[i] <= '0;
            end
        end else if (rf_we && rf_wa != '0) begin
            shadow[rf_wa] <= rf_wd;                 // x0 stays zero
        end
    end

    assign rs1_val = shadow[instr[19:15]];
    assign rs2_val = shadow[instr[24:20]];

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};   // sw only
    endfunction

    function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t random_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = lcg_next();
        rd  = {2'b00, r[2:0]};     // x0 to x7
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        case ((lcg_next() >> 8) % 20)
            0:       return r_type(7'h00, rs2, rs1, 3'b000, rd);   // add
            1:       return r_type(7'h20, rs2, rs1, 3'b000, rd);   // sub
            2:       return r_type(7'h00, rs2, rs1, 3'b111, rd);
            3:       return r_type(7'h00, rs2, rs1, 3'b110, rd);
            4:       return r_type(7'h00, rs2, rs1, 3'b100, rd);
            5:       return r_type(7'h00, rs2, rs1, 3'b001, rd);   // sll
            6:       return r_type(7'h00, rs2, rs1, 3'b101, rd);   // srl
            7:       return r_type(7'h00, rs2, rs1, 3'b010, rd);   // slt
            8:       return i_type(r[20:9], rs1, 3'b000, rd);      // addi
            9:       return i_type(r[20:9], rs1, 3'b111, rd);
            10:      return i_type(r[20:9], rs1, 3'b110, rd);
            11:      return i_type(r[20:9], rs1, 3'b100, rd);
            12:      return i_type({7'h00, r[13:9]}, rs1, 3'b001, rd);   // slli
            13:      return i_type({7'h00, r[13:9]}, rs1, 3'b101, rd);   // srli
            14:      return u_type(r[31:12], rd);                  // lui
            15:      return s_type(r[20:9], rs2, rs1);
            16:      return b_type({r[20:9], 1'b0}, rs2, rs1, 3'b000);   // beq
            17:      return b_type({r[20:9], 1'b0}, rs2, rs1, 3'b001);   // bne
            18:      return b_type({r[20:9], 1'b0}, rs2, rs1, 3'b100);   // blt
            default: return b_type({r[20:9], 1'b0}, rs2, rs1, 3'b101);   // bge
        endcase
    endfunction

    task automatic issue(input word_t ins, input logic vld);
        @(posedge clk);
        instr     <= ins;
        instr_vld <= vld;
    endtask

    initial begin : stimulus
        instr     = '0;
        instr_vld = 1'b0;
        arst_n    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        // known values into x1 to x7
        for (int r = 1; r < 8; r++) begin
            issue(u_type({4'(r), 16'hc35a}, 5'(r)), 1'b1);
            issue(i_type(12'(12'h800 + r * 12'h13b), 5'(r), 3'b000, 5'(r)), 1'b1);
        end
        issue(i_type(12'h123, 5'd0, 3'b000, 5'd0), 1'b1);      // addi x0 discarded
        issue(u_type(20'habcde, 5'd0), 1'b1);                    // lui x0 discarded
        issue(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd3), 1'b1);    // add x3 x0 x1
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd4), 1'b1);    // add x4 x0 x0
        issue(s_type(12'hff8, 5'd2, 5'd1), 1'b1);                // sw x2 -8(x1)
        issue(b_type(13'h0010, 5'd1, 5'd1, 3'b000), 1'b1);       // beq taken
        for (int n = 0; n < RANDOM_NUM; n++) begin
            if (n % 16 == 15) issue(random_instr(), 1'b0);       // bubble with live opcode
            issue(random_instr(), 1'b1);
        end
        issue('0, 1'b0);
        repeat (2) @(posedge clk);                               // let last checks fire
        @(negedge clk);                                          // last edge fully settled
        if (rv_exec_top_i.rv_exec_assertions_i.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "%0d assertion failures", rv_exec_top_i.rv_exec_assertions_i.fail_cnt);
        end
    end

    initial begin : watchdog
        wait (rv_exec_top_i.rv_exec_assertions_i.fail_cnt != 0 || cycle_cnt >= TIMEOUT_CYCLES);
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end else begin
            $display("an assertion failed at cycle %0d", cycle_cnt);
        end
        $display("Test FAILED");
        $fatal(1, "stopped on first error");
    end

endmodule : tb_rv_exec

// ==== dv/rv_exec_assertions.sv ====
// execute slice checker: result rules for write-back, store, branch and idle strobes

module rv_exec_assertions
    import rv_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input word_t     instr,
    input logic      instr_vld,
    input logic      rf_we,
    input reg_addr_t rf_wa,
    input word_t     rf_wd,
    input logic      dm_we,
    input word_t     dm_addr,
    input word_t     dm_wdata,
    input logic      pc_src,
    input word_t     br_offset,
    input word_t     rs1_val,    // shadow value of rs1
    input word_t     rs2_val     // shadow value of rs2
);

    int unsigned fail_cnt = 0;   // bumped by every failing check

    logic [6:0] opc;         // full 7-bit opcode
    logic [2:0] f3;
    word_t      src_b;       // rs2 or i-immediate
    word_t      imm_s;
    word_t      imm_b;
    word_t      exp_wd;      // architectural op / op-imm result
    logic       exp_taken;   // architectural branch outcome

    assign opc   = instr[6:0];
    assign f3    = instr[14:12];
    assign src_b = (opc == 7'h13) ? {{20{instr[31]}}, instr[31:20]} : rs2_val;
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (f3)
            3'b000:  exp_wd = (opc == 7'h33 && instr[30]) ? rs1_val - src_b : rs1_val + src_b;
            3'b001:  exp_wd = rs1_val << src_b[4:0];
            3'b010:  exp_wd = {31'd0, $signed(rs1_val) < $signed(src_b)};
            3'b100:  exp_wd = rs1_val ^ src_b;
            3'b101:  exp_wd = rs1_val >> src_b[4:0];    // zero fill
            3'b110:  exp_wd = rs1_val | src_b;
            default: exp_wd = rs1_val & src_b;
        endcase
        case (f3)
            3'b000:  exp_taken = (rs1_val == rs2_val);
            3'b001:  exp_taken = (rs1_val != rs2_val);
            3'b100:  exp_taken = ($signed(rs1_val) < $signed(rs2_val));
            default: exp_taken = ($signed(rs1_val) >= $signed(rs2_val));
        endcase
    end

    a_arith: assert property (@(posedge clk) disable iff (!arst_n)
        instr_vld && (opc == 7'h33 || opc == 7'h13)
            |-> rf_we && rf_wa == instr[11:7] && rf_wd == exp_wd)
    else begin
        fail_cnt++;
        $error("MISMATCH arith expected rd %0d value %h actual rd %0d value %h",
               $sampled(instr[11:7]), $sampled(exp_wd), $sampled(rf_wa), $sampled(rf_wd));
    end

    a_lui: assert property (@(posedge clk) disable iff (!arst_n)
        instr_vld && opc == 7'h37
            |-> rf_we && rf_wa == instr[11:7] && rf_wd == {instr[31:12], 12'h000})
    else begin
        fail_cnt++;
        $error("MISMATCH lui expected rd %0d value %h actual rd %0d value %h",
               $sampled(instr[11:7]), $sampled({instr[31:12], 12'h000}),
               $sampled(rf_wa), $sampled(rf_wd));
    end

    // add with rs1 = x0 must return rs2 unchanged
    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        instr_vld && opc == 7'h33 && f3 == 3'b000 && !instr[30] && instr[19:15] == 5'd0
            |-> rf_wd == rs2_val)
    else begin
        fail_cnt++;
        $error("MISMATCH x0_zero expected %h actual %h", $sampled(rs2_val), $sampled(rf_wd));
    end

    a_sw: assert property (@(posedge clk) disable iff (!arst_n)
        instr_vld && opc == 7'h23
            |-> dm_we && !rf_we && dm_addr == rs1_val + imm_s && dm_wdata == rs2_val)
    else begin
        fail_cnt++;
        $error("MISMATCH sw expected addr %h data %h actual addr %h data %h",
               $sampled(rs1_val + imm_s), $sampled(rs2_val),
               $sampled(dm_addr), $sampled(dm_wdata));
    end

    a_branch: assert property (@(posedge clk) disable iff (!arst_n)
        instr_vld && opc == 7'h63
            |-> pc_src == exp_taken && br_offset == imm_b && !rf_we && !dm_we)
    else begin
        fail_cnt++;
        $error("MISMATCH branch expected taken %b offset %h actual taken %b offset %h",
               $sampled(exp_taken), $sampled(imm_b), $sampled(pc_src), $sampled(br_offset));
    end

    a_idle: assert property (@(posedge clk)
        !arst_n || !instr_vld |-> !rf_we && !dm_we && !pc_src)
    else begin
        fail_cnt++;
        $error("write, store or branch strobe high without a valid instruction");
    end

endmodule : rv_exec_assertions

// ==== design/rv_exec_top.sv ====
// rv32i execute slice top: decode, register file and alu with write-back, store and branch ports

module rv_exec_top
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  word_t     instr,       // instruction to execute
    input  logic      instr_vld,   // instr holds a real instruction
    output logic      rf_we,       // register write strobe
    output reg_addr_t rf_wa,       // rd
    output word_t     rf_wd,       // write-back value
    output logic      dm_we,       // store strobe
    output word_t     dm_addr,     // store address
    output word_t     dm_wdata,    // store data, rs2
    output logic      pc_src,      // branch taken
    output word_t     br_offset    // branch target offset
);

    reg_addr_t  ra1;
    reg_addr_t  ra2;
    reg_addr_t  wa3;
    logic [4:0] instr_shamt;   // shamt field of slli/srli
    logic [4:0] alu_shamt;     // shift distance into alu
    word_t      imm_ext;
    word_t      rd1;
    word_t      rd2;
    word_t      alu_b;
    word_t      alu_result;
    ctrl_t      ctrl;
    logic       br_taken;      // ungated branch decision

    rv_instr_decode rv_instr_decode_i (
        .instr   (instr),
        .rd1     (rd1),
        .rd2     (rd2),
        .ra1     (ra1),
        .ra2     (ra2),
        .wa3     (wa3),
        .shamt   (instr_shamt),
        .imm_ext (imm_ext),
        .ctrl    (ctrl),
        .pc_src  (br_taken)
    );

    rv_reg_file rv_reg_file_i (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (ra1),
        .ra2    (ra2),
        .rd1    (rd1),
        .rd2    (rd2),
        .we     (rf_we),
        .wa     (wa3),
        .wd     (rf_wd)
    );

    assign alu_b     = ctrl.src_b_imm ? imm_ext : rd2;
    assign alu_shamt = ctrl.src_b_imm ? instr_shamt : rd2[4:0];   // sll/srl use rs2 low bits

    rv_alu rv_alu_i (
        .a      (rd1),
        .b      (alu_b),
        .shamt  (alu_shamt),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    // strobes only count while the instruction is valid
    assign rf_we     = instr_vld & ctrl.we_rf;
    assign dm_we     = instr_vld & ctrl.we_dm;
    assign pc_src    = instr_vld & br_taken;

    assign rf_wa     = wa3;
    assign rf_wd     = ctrl.wb_imm ? imm_ext : alu_result;   // lui bypasses alu
    assign dm_addr   = alu_result;                           // rs1 + s-imm
    assign dm_wdata  = rd2;
    assign br_offset = imm_ext;                              // b-imm when branching

endmodule : rv_exec_top

// ==== design/rv_alu.sv ====
// alu: add, sub, and, or, xor, logical shifts and signed set-less-than

`include "rv_cfg.svh"

module rv_alu
    import rv_pkg::*;
(
    input  word_t      a,        // operand a, rs1
    input  word_t      b,        // operand b, rs2 or immediate
    input  logic [4:0] shamt,    // shift distance
    input  alu_op_t    op,       // operation
    output word_t      result
);

    word_t sum;    // shared by add and address calc
    word_t diff;
    logic  lt;     // signed a < b

    assign sum  = a + b;
    assign diff = a - b;
    assign lt   = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;          // logical, zero fill
            ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, lt};
            default: result = sum;
        endcase
    end

endmodule : rv_alu

// ==== design/rv_reg_file.sv ====
// register file: 32 words, two asynchronous reads and one clocked write, x0 hardwired zero

`include "rv_cfg.svh"

module rv_reg_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t ra1,    // read port 1 index
    input  reg_addr_t ra2,    // read port 2 index
    output word_t     rd1,    // read port 1 data
    output word_t     rd2,    // read port 2 data
    input  logic      we,     // write enable
    input  reg_addr_t wa,     // write index
    input  word_t     wd      // write data
);

    word_t regs [`RV_REG_NUM];   // x0 slot never written

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;                      // whole file cleared
            end
        end else if (we && wa != '0) begin          // drop writes to x0
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule : rv_reg_file

// ==== design/rv_instr_decode.sv ====
// instruction decode: field split, control unit, immediate generator and branch unit

module rv_instr_decode
    import rv_pkg::*;
(
    input  word_t      instr,    // current instruction
    input  word_t      rd1,      // rs1 value from register file
    input  word_t      rd2,      // rs2 value from register file
    output reg_addr_t  ra1,      // rs1 index
    output reg_addr_t  ra2,      // rs2 index
    output reg_addr_t  wa3,      // rd index
    output logic [4:0] shamt,    // immediate shift amount
    output word_t      imm_ext,  // extended immediate
    output ctrl_t      ctrl,     // decoded control
    output logic       pc_src    // branch taken
);

    logic [4:0] opcode;   // major opcode, low two bits dropped
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign ra1    = instr[19:15];
    assign ra2    = instr[24:20];
    assign wa3    = instr[11:7];
    assign shamt  = instr[24:20];   // same slot as rs2

    rv_control_unit rv_control_unit_i (
        .opcode  (opcode),
        .funct3  (funct3),
        .funct7  (funct7),
        .ctrl    (ctrl)
    );

    rv_sign_ex rv_sign_ex_i (
        .instr   (instr),
        .imm_sel (ctrl.imm_sel),
        .imm_ext (imm_ext)
    );

    rv_branch_unit rv_branch_unit_i (
        .br_type (ctrl.br_type),
        .rd1     (rd1),
        .rd2     (rd2),
        .pc_src  (pc_src)
    );

endmodule : rv_instr_decode

// ==== design/rv_branch_unit.sv ====
// branch unit: compares the two register operands for the decoded branch type

module rv_branch_unit
    import rv_pkg::*;
(
    input  br_type_t br_type,  // from control unit
    input  word_t    rd1,      // rs1 value
    input  word_t    rd2,      // rs2 value
    output logic     pc_src    // branch taken
);

    logic equal;    // rs1 == rs2
    logic less;     // signed rs1 < rs2

    assign equal = (rd1 == rd2);
    assign less  = ($signed(rd1) < $signed(rd2));

    always_comb begin
        case (br_type)
            BR_EQ:   pc_src = equal;
            BR_NE:   pc_src = !equal;
            BR_LT:   pc_src = less;
            BR_GE:   pc_src = !less;
            default: pc_src = 1'b0;    // not a branch
        endcase
    end

endmodule : rv_branch_unit

// ==== design/rv_sign_ex.sv ====
// immediate generator: reassembles and sign-extends the I, S, B or U immediate

`include "rv_cfg.svh"

module rv_sign_ex
    import rv_pkg::*;
(
    input  word_t    instr,     // raw instruction
    input  imm_sel_t imm_sel,   // immediate format
    output word_t    imm_ext    // extended immediate
);

    logic [11:0] imm_i;  // addi family
    logic [11:0] imm_s;  // store offset
    logic [12:0] imm_b;  // branch offset, bit 0 zero
    logic [19:0] imm_u;  // upper immediate

    assign imm_i = instr[31:20];
    assign imm_s = {instr[31:25], instr[11:7]};
    assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = instr[31:12];

    always_comb begin
        case (imm_sel)
            IMM_I:   imm_ext = {{(`RV_XLEN-12){imm_i[11]}}, imm_i};
            IMM_S:   imm_ext = {{(`RV_XLEN-12){imm_s[11]}}, imm_s};
            IMM_B:   imm_ext = {{(`RV_XLEN-13){imm_b[12]}}, imm_b};
            default: imm_ext = {imm_u, 12'h000};   // u-type over zero low bits
        endcase
    end

endmodule : rv_sign_ex

// ==== design/rv_control_unit.sv ====
// rv32i control unit: opcode, funct3 and funct7 to the decoded control word

module rv_control_unit
    import rv_pkg::*;
(
    input  logic [4:0] opcode,   // instr[6:2]
    input  logic [2:0] funct3,   // instr[14:12]
    input  logic [6:0] funct7,   // instr[31:25]
    output ctrl_t      ctrl      // decoded control
);

    // major opcodes, instr[6:2]
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;

    alu_op_t f3_op;     // alu op from funct3 alone
    logic    f3_ok;     // funct3 names a supported op
    logic    is_shift;  // sll or srl encoding
    logic    r_ok;      // legal register-register form
    logic    i_ok;      // legal register-immediate form

    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;           // sltu not in this slice
                f3_ok = 1'b0;
            end
        endcase
    end

    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign r_ok     = f3_ok && (funct7 == 7'b0000000);
    // slti not supported, shifts need funct7 clear (no srai)
    assign i_ok     = f3_ok && (funct3 != 3'b010) && (!is_shift || funct7 == 7'b0000000);

    always_comb begin
        ctrl = '0;                              // unsupported: all enables low
        case (opcode)
            OPC_OP: begin
                if (r_ok) begin
                    ctrl.alu_op = f3_op;
                    ctrl.we_rf  = 1'b1;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctrl.alu_op = ALU_SUB;      // funct7[5] selects sub
                    ctrl.we_rf  = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (i_ok) begin
                    ctrl.alu_op    = f3_op;
                    ctrl.src_b_imm = 1'b1;
                    ctrl.imm_sel   = IMM_I;
                    ctrl.we_rf     = 1'b1;
                end
            end
            OPC_LUI: begin
                ctrl.wb_imm  = 1'b1;            // bypass alu
                ctrl.imm_sel = IMM_U;
                ctrl.we_rf   = 1'b1;
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin     // sw only
                    ctrl.alu_op    = ALU_ADD;   // address = rs1 + imm
                    ctrl.src_b_imm = 1'b1;
                    ctrl.imm_sel   = IMM_S;
                    ctrl.we_dm     = 1'b1;
                end
            end
            OPC_BRANCH: begin
                ctrl.imm_sel = IMM_B;
                case (funct3)
                    3'b000:  ctrl.br_type = BR_EQ;
                    3'b001:  ctrl.br_type = BR_NE;
                    3'b100:  ctrl.br_type = BR_LT;
                    3'b101:  ctrl.br_type = BR_GE;
                    default: ctrl.br_type = BR_NONE;   // bltu, bgeu not supported
                endcase
            end
            default: ;
        endcase
    end

endmodule : rv_control_unit

// ==== design/rv_pkg.sv ====
// rv32i execute slice types: data words, operation codes and the decoded control word

`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;       // operand, result, immediate
    typedef logic [`RV_RA_W-1:0] reg_addr_t;   // register index
    typedef logic [2:0]          alu_op_t;     // alu operation code
    typedef logic [1:0]          imm_sel_t;    // immediate format
    typedef logic [2:0]          br_type_t;    // branch compare kind

    // alu operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLL = 3'd5;
    localparam alu_op_t ALU_SRL = 3'd6;
    localparam alu_op_t ALU_SLT = 3'd7;

    // immediate formats
    localparam imm_sel_t IMM_I = 2'd0;
    localparam imm_sel_t IMM_S = 2'd1;
    localparam imm_sel_t IMM_B = 2'd2;
    localparam imm_sel_t IMM_U = 2'd3;

    // branch types, none means not a branch
    localparam br_type_t BR_NONE = 3'd0;
    localparam br_type_t BR_EQ   = 3'd1;
    localparam br_type_t BR_NE   = 3'd2;
    localparam br_type_t BR_LT   = 3'd3;
    localparam br_type_t BR_GE   = 3'd4;

    // decoded control, 12 bits
    typedef struct packed {
        alu_op_t  alu_op;      // alu operation
        logic     src_b_imm;   // operand b from immediate
        logic     wb_imm;      // write back immediate (lui)
        logic     we_rf;       // register file write
        logic     we_dm;       // store
        imm_sel_t imm_sel;     // immediate format
        br_type_t br_type;     // branch compare
    } ctrl_t;

endpackage : rv_pkg

// ==== design/rv_cfg.svh ====
// rv32i execute slice configuration: data width and register file geometry

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data path word width, rv32i
`define RV_XLEN     32

// architectural register count, x0 to x31
`define RV_REG_NUM  32

// register index width, log2 of RV_REG_NUM
`define RV_RA_W     5

`endif
